//--- Bender.yml
package:
  name: decodeStage

sources:
  - decodePkg.sv
  - ctrlIf.sv
  - aluCtrlIf.sv
  - mainDecoder.sv
  - aluDecoder.sv
  - operandFields.sv
  - decodeStage.sv
  - target: test
    files:
      - clockGen.sv
      - decodeStageTb.sv

//--- aluCtrlIf.sv
`timescale 1ns/1ns
`default_nettype none

interface aluCtrlIf;
    import decodePkg::*;

    logic [aluOpW-1:0] aluOp;
    logic              aluInvA;  // Invert A before the adder
    logic              aluInvB;
    logic              aluCin;   // Completes two's complement on subtract

    modport decoder (output aluOp, aluInvA, aluInvB, aluCin);
    modport stage   (input aluOp, aluInvA, aluInvB, aluCin);
endinterface

`default_nettype wire

//--- aluDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module aluDecoder (
    input  logic [decodePkg::opcodeW-1:0] opcode,
    input  logic [1:0]                    func,   // Instruction bits 1..0
    aluCtrlIf.decoder                     alu
);
    import decodePkg::*;

    always_comb begin
        alu.aluOp   = aluRol;
        alu.aluInvA = 1'b0;
        alu.aluInvB = 1'b0;
        alu.aluCin  = 1'b0;

        case (opcode)
            // Address and target adds
            opAddi, opSt, opLd, opStu, opJr, opJalr: alu.aluOp = aluAdd;
            opSubi: begin
                alu.aluOp   = aluAdd;    // imm - Rs
                alu.aluInvA = 1'b1;
                alu.aluCin  = 1'b1;
            end
            opXori: alu.aluOp = aluXor;
            opAndni: begin
                alu.aluOp   = aluAnd;
                alu.aluInvB = 1'b1;      // Rs & ~imm
            end
            opRoli: alu.aluOp = aluRol;
            opSlli: alu.aluOp = aluSll;
            opRori: alu.aluOp = aluRor;
            opSrli: alu.aluOp = aluSrl;
            opBtr:  alu.aluOp = aluBtr;

            // Compares subtract Rt from Rs
            opSeq, opSlt, opSle: begin
                alu.aluOp   = (opcode == opSeq) ? aluSeq :
                              (opcode == opSlt) ? aluSlt : aluSle;
                alu.aluInvB = 1'b1;
                alu.aluCin  = 1'b1;
            end
            opSco:  alu.aluOp = aluSco;
            opBeqz, opBnez, opBltz, opBgez: alu.aluOp = aluPassA;  // Rs tested downstream
            opLbi:  alu.aluOp = aluPassB;
            opSlbi: alu.aluOp = aluSlbi;

            opShiftR: alu.aluOp = aluOpW'(func);  // func lines up with the shifter codes
            opArithR: begin
                alu.aluCin = func[0];    // Only SUB needs it and AND ignores it
                case (func)
                    2'd0: alu.aluOp = aluAdd;
                    2'd1: begin
                        alu.aluOp   = aluAdd;  // Rt - Rs
                        alu.aluInvA = 1'b1;
                    end
                    2'd2: alu.aluOp = aluXor;
                    default: begin
                        alu.aluOp   = aluAnd;
                        alu.aluInvB = 1'b1;
                    end
                endcase
            end
            default: begin
                // Halt, nop and J/JAL leave the ALU idle
            end
        endcase
    end
endmodule

`default_nettype wire

//--- clockGen.sv
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
    parameter int halfPeriod  = 4,  // 8 ns clock
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic rstN
);
    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;  // Release on an edge like any other stimulus
    end
endmodule

`default_nettype wire

//--- ctrlIf.sv
`timescale 1ns/1ns
`default_nettype none

interface ctrlIf;
    import decodePkg::*;

    logic [regDstW-1:0] regDst;   // Write register select
    logic [extSelW-1:0] extSel;   // Immediate extension mode
    logic               regWrite;
    logic               memRead;
    logic               memWrite;
    logic               memToReg; // Write back load data
    logic               aluSrc;   // Immediate as ALU B operand
    logic               jump;
    logic               branch;
    logic               regToPc;  // JR/JALR target from register
    logic               pcToReg;  // PC + 2 into link register
    logic               halt;
    logic               err;

    modport decoder (output regDst, extSel, regWrite, memRead, memWrite, memToReg,
                     aluSrc, jump, branch, regToPc, pcToReg, halt, err);

    // Operand path only needs the two selects
    modport fields (input regDst, extSel);

    modport stage (input regWrite, memRead, memWrite, memToReg, aluSrc, jump, branch,
                   regToPc, pcToReg, halt, err);
endinterface

`default_nettype wire

//--- decodePkg.sv
`default_nettype none

package decodePkg;

    //////////////////////////////////////////////////////////////////////
    // Field widths
    //////////////////////////////////////////////////////////////////////
    localparam int dataW   = 16;  // Instruction and data width
    localparam int opcodeW = 5;
    localparam int regIdxW = 3;   // Eight registers
    localparam int aluOpW  = 4;
    localparam int extSelW = 3;
    localparam int regDstW = 2;

    localparam logic [regIdxW-1:0] linkReg = 3'd7;  // R7 takes PC + 2 on JAL/JALR

    //////////////////////////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////////////////////////
    localparam logic [opcodeW-1:0] opHalt   = 5'b00000, opNop    = 5'b00001;
    localparam logic [opcodeW-1:0] opSiic   = 5'b00010, opRti    = 5'b00011;
    localparam logic [opcodeW-1:0] opJ      = 5'b00100, opJr     = 5'b00101;
    localparam logic [opcodeW-1:0] opJal    = 5'b00110, opJalr   = 5'b00111;
    localparam logic [opcodeW-1:0] opAddi   = 5'b01000, opSubi   = 5'b01001;
    localparam logic [opcodeW-1:0] opXori   = 5'b01010, opAndni  = 5'b01011;
    localparam logic [opcodeW-1:0] opBeqz   = 5'b01100, opBnez   = 5'b01101;
    localparam logic [opcodeW-1:0] opBltz   = 5'b01110, opBgez   = 5'b01111;
    localparam logic [opcodeW-1:0] opSt     = 5'b10000, opLd     = 5'b10001;
    localparam logic [opcodeW-1:0] opSlbi   = 5'b10010, opStu    = 5'b10011;
    localparam logic [opcodeW-1:0] opRoli   = 5'b10100, opSlli   = 5'b10101;
    localparam logic [opcodeW-1:0] opRori   = 5'b10110, opSrli   = 5'b10111;
    localparam logic [opcodeW-1:0] opLbi    = 5'b11000, opBtr    = 5'b11001;
    localparam logic [opcodeW-1:0] opShiftR = 5'b11010, opArithR = 5'b11011;
    localparam logic [opcodeW-1:0] opSeq    = 5'b11100, opSlt    = 5'b11101;
    localparam logic [opcodeW-1:0] opSle    = 5'b11110, opSco    = 5'b11111;

    // ALU operations
    localparam logic [aluOpW-1:0] aluRol   = 4'd0;   // Shifter group sits at 0..3
    localparam logic [aluOpW-1:0] aluSll   = 4'd1;
    localparam logic [aluOpW-1:0] aluRor   = 4'd2;
    localparam logic [aluOpW-1:0] aluSrl   = 4'd3;
    localparam logic [aluOpW-1:0] aluAdd   = 4'd4;
    localparam logic [aluOpW-1:0] aluAnd   = 4'd5;
    localparam logic [aluOpW-1:0] aluXor   = 4'd7;
    localparam logic [aluOpW-1:0] aluBtr   = 4'd8;   // Bit reverse
    localparam logic [aluOpW-1:0] aluSeq   = 4'd9;
    localparam logic [aluOpW-1:0] aluSlt   = 4'd10;
    localparam logic [aluOpW-1:0] aluSle   = 4'd11;
    localparam logic [aluOpW-1:0] aluSco   = 4'd12;  // Carry out of Rs + Rt
    localparam logic [aluOpW-1:0] aluPassB = 4'd13;
    localparam logic [aluOpW-1:0] aluSlbi  = 4'd14;  // (A << 8) | B
    localparam logic [aluOpW-1:0] aluPassA = 4'd15;

    // Immediate extension modes
    localparam logic [extSelW-1:0] extSign5  = 3'd0;
    localparam logic [extSelW-1:0] extSign8  = 3'd1;
    localparam logic [extSelW-1:0] extSign11 = 3'd2;
    localparam logic [extSelW-1:0] extZero5  = 3'd3;
    localparam logic [extSelW-1:0] extZero8  = 3'd4;

    // Write register source
    localparam logic [regDstW-1:0] dstRs   = 2'd0;  // Bits 10..8
    localparam logic [regDstW-1:0] dstRt   = 2'd1;  // Bits 7..5
    localparam logic [regDstW-1:0] dstRd   = 2'd2;  // Bits 4..2
    localparam logic [regDstW-1:0] dstLink = 2'd3;

    //////////////////////////////////////////////////////////////////////
    // Instruction word views
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [opcodeW-1:0] opcode;
        logic [regIdxW-1:0] rs;
        logic [regIdxW-1:0] rt;
        logic [regIdxW-1:0] rd;
        logic [1:0]         func;  // Selects the op inside ShiftR/ArithR
    } rFmt_s;

    typedef struct packed {
        logic [opcodeW-1:0] opcode;
        logic [regIdxW-1:0] rs;
        logic [regIdxW-1:0] rd;
        logic [4:0]         imm5;
    } i1Fmt_s;

    typedef struct packed {
        logic [opcodeW-1:0] opcode;
        logic [regIdxW-1:0] rs;
        logic [7:0]         imm8;
    } i2Fmt_s;

    typedef struct packed {
        logic [opcodeW-1:0] opcode;
        logic [10:0]        disp11;  // PC relative
    } jFmt_s;

    typedef union packed {
        rFmt_s  rFmt;
        i1Fmt_s i1Fmt;
        i2Fmt_s i2Fmt;
        jFmt_s  jFmt;
    } instrWord_u;

endpackage

`default_nettype wire

//--- decodeStage.f
decodePkg.sv
ctrlIf.sv
aluCtrlIf.sv
mainDecoder.sv
aluDecoder.sv
operandFields.sv
decodeStage.sv
clockGen.sv
decodeStageTb.sv

//--- decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           instrValid,
    input  logic [decodePkg::dataW-1:0]    instr,
    output logic                           ctrlValid,
    output logic                           regWrite,
    output logic                           memRead,
    output logic                           memWrite,
    output logic                           memToReg,
    output logic                           aluSrc,
    output logic                           jump,
    output logic                           branch,
    output logic                           regToPc,
    output logic                           pcToReg,
    output logic                           halt,
    output logic                           err,
    output logic [decodePkg::regIdxW-1:0]  writeReg,
    output logic [decodePkg::aluOpW-1:0]   aluOp,
    output logic                           aluInvA,
    output logic                           aluInvB,
    output logic                           aluCin,
    output logic [decodePkg::dataW-1:0]    immValue
);
    import decodePkg::*;

    instrWord_u          instrW;        // Same word seen through the format views
    logic [dataW-1:0]    immNext;
    logic [regIdxW-1:0]  writeRegNext;

    ctrlIf    ctrlBus ();
    aluCtrlIf aluBus ();

    assign instrW = instr;

    //////////////////////////////////////////////////////////////////////
    // Combinational decode
    //////////////////////////////////////////////////////////////////////
    mainDecoder u_mainDecoder (
        .opcode (instrW.rFmt.opcode),
        .ctrl   (ctrlBus.decoder)
    );

    aluDecoder u_aluDecoder (
        .opcode (instrW.rFmt.opcode),
        .func   (instrW.rFmt.func),
        .alu    (aluBus.decoder)
    );

    operandFields u_operandFields (
        .instr    (instrW),
        .ctrl     (ctrlBus.fields),
        .immValue (immNext),
        .writeReg (writeRegNext)
    );

    //////////////////////////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlValid <= 1'b0;
            regWrite  <= 1'b0;
            memRead   <= 1'b0;
            memWrite  <= 1'b0;
            jump      <= 1'b0;
            branch    <= 1'b0;
            halt      <= 1'b0;
            err       <= 1'b0;
            memToReg  <= 1'b0;
            aluSrc    <= 1'b0;
            regToPc   <= 1'b0;
            pcToReg   <= 1'b0;
            writeReg  <= '0;
            aluOp     <= '0;
            aluInvA   <= 1'b0;
            aluInvB   <= 1'b0;
            aluCin    <= 1'b0;
            immValue  <= '0;
        end else begin
            ctrlValid <= instrValid;
            regWrite  <= instrValid & ctrlBus.regWrite;  // Enables drop in a bubble
            memRead   <= instrValid & ctrlBus.memRead;
            memWrite  <= instrValid & ctrlBus.memWrite;
            jump      <= instrValid & ctrlBus.jump;
            branch    <= instrValid & ctrlBus.branch;
            halt      <= instrValid & ctrlBus.halt;
            err       <= instrValid & ctrlBus.err;
            if (instrValid) begin                         // Payload holds otherwise
                memToReg <= ctrlBus.memToReg;
                aluSrc   <= ctrlBus.aluSrc;
                regToPc  <= ctrlBus.regToPc;
                pcToReg  <= ctrlBus.pcToReg;
                writeReg <= writeRegNext;
                aluOp    <= aluBus.aluOp;
                aluInvA  <= aluBus.aluInvA;
                aluInvB  <= aluBus.aluInvB;
                aluCin   <= aluBus.aluCin;
                immValue <= immNext;
            end
        end
    end
endmodule

`default_nettype wire

//--- decodeStageTb.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStageTb;
    import decodePkg::*;

    localparam int clkPeriod   = 8;
    localparam int resetCycles = 8;
    localparam int totalInstr  = resetCycles + 32 + 8 + 200 + 300;
    localparam int timeoutNs   = (totalInstr + 100) * clkPeriod;

    // Expected view of the registered outputs
    typedef struct packed {
        logic               regWrite;
        logic               memRead;
        logic               memWrite;
        logic               memToReg;
        logic               aluSrc;
        logic               jump;
        logic               branch;
        logic               regToPc;
        logic               pcToReg;
        logic               halt;
        logic               err;
        logic [regIdxW-1:0] writeReg;
        logic [aluOpW-1:0]  aluOp;
        logic               aluInvA;
        logic               aluInvB;
        logic               aluCin;
        logic [dataW-1:0]   immValue;
    } ctrlBundle_s;

    logic clk, rstN, instrValid, ctrlValid;
    logic [dataW-1:0] instr, immValue;
    logic regWrite, memRead, memWrite, memToReg, aluSrc, jump, branch;
    logic regToPc, pcToReg, halt, err, aluInvA, aluInvB, aluCin;
    logic [regIdxW-1:0] writeReg;
    logic [aluOpW-1:0]  aluOp;

    logic [31:0] lcgState = 32'h8d7c;
    string       testName = "none";
    int          testErrors, totalErrors, testsRun, testsFailed;
    logic        expValid;
    ctrlBundle_s expBundle;

    clockGen #(.halfPeriod(clkPeriod / 2), .resetCycles(resetCycles)) u_clockGen (
        .clk  (clk),
        .rstN (rstN)
    );

    decodeStage u_decodeStage (.*);

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    function automatic ctrlBundle_s refDecode(input logic [dataW-1:0] w);
        ctrlBundle_s        b;
        logic [4:0]         op;
        logic [1:0]         fn;
        logic [extSelW-1:0] ext;
        logic [regDstW-1:0] dst;
        op = w[15:11];
        fn = w[1:0];
        b  = '0;
        b.halt     = (op == opHalt);
        b.memRead  = (op == opLd);
        b.memToReg = (op == opLd);
        b.memWrite = op inside {opSt, opStu};
        b.branch   = op inside {opBeqz, opBnez, opBltz, opBgez};
        b.jump     = op inside {opJ, opJr, opJal, opJalr};
        b.regToPc  = op inside {opJr, opJalr};  // Register based targets
        b.pcToReg  = op inside {opJal, opJalr};
        b.aluSrc   = op inside {opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori,
                                opSrli, opSt, opLd, opStu, opLbi, opSlbi, opJr, opJalr};
        b.regWrite = op inside {opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori,
                                opSrli, opLd, opStu, opBtr, opShiftR, opArithR, opSeq,
                                opSlt, opSle, opSco, opLbi, opSlbi, opJal, opJalr};
        // Destination field
        if (op inside {opJal, opJalr}) dst = dstLink;
        else if (op inside {opBtr, opShiftR, opArithR, opSeq, opSlt, opSle, opSco}) dst = dstRd;
        else if (op inside {opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli,
                            opLd}) dst = dstRt;
        else dst = dstRs;
        // Extension mode
        if (op inside {opXori, opAndni, opRoli, opSlli, opRori, opSrli}) ext = extZero5;
        else if (op == opSlbi) ext = extZero8;
        else if (op inside {opBeqz, opBnez, opBltz, opBgez, opLbi, opJr, opJalr}) ext = extSign8;
        else if (op inside {opJ, opJal}) ext = extSign11;
        else ext = extSign5;
        case (ext)
            extSign8:  b.immValue = {{8{w[7]}}, w[7:0]};
            extSign11: b.immValue = {{5{w[10]}}, w[10:0]};
            extZero5:  b.immValue = {11'b0, w[4:0]};
            extZero8:  b.immValue = {8'b0, w[7:0]};
            default:   b.immValue = {{11{w[4]}}, w[4:0]};
        endcase
        case (dst)
            dstRt:   b.writeReg = w[7:5];
            dstRd:   b.writeReg = w[4:2];
            dstLink: b.writeReg = linkReg;
            default: b.writeReg = w[10:8];
        endcase
        // ALU controls
        b.aluInvA = (op == opSubi) || (op == opArithR && fn == 2'd1);
        b.aluInvB = op inside {opAndni, opSeq, opSlt, opSle} || (op == opArithR && fn == 2'd3);
        b.aluCin  = op inside {opSubi, opSeq, opSlt, opSle} || (op == opArithR && fn[0]);
        case (op)
            opAddi, opSubi, opSt, opLd, opStu, opJr, opJalr: b.aluOp = aluAdd;
            opXori:  b.aluOp = aluXor;
            opAndni: b.aluOp = aluAnd;
            opSlli:  b.aluOp = aluSll;
            opRori:  b.aluOp = aluRor;
            opSrli:  b.aluOp = aluSrl;
            opBtr:   b.aluOp = aluBtr;
            opSeq:   b.aluOp = aluSeq;
            opSlt:   b.aluOp = aluSlt;
            opSle:   b.aluOp = aluSle;
            opSco:   b.aluOp = aluSco;
            opBeqz, opBnez, opBltz, opBgez: b.aluOp = aluPassA;
            opLbi:   b.aluOp = aluPassB;
            opSlbi:  b.aluOp = aluSlbi;
            opShiftR: b.aluOp = (fn == 2'd0) ? aluRol : (fn == 2'd1) ? aluSll :
                                (fn == 2'd2) ? aluRor : aluSrl;
            opArithR: b.aluOp = (fn == 2'd2) ? aluXor : (fn == 2'd3) ? aluAnd : aluAdd;
            default: b.aluOp = aluRol;  // Idle ALU, roli included
        endcase
        return b;
    endfunction

    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic randWord(output logic [dataW-1:0] w);
        lcgState = lcgStep(lcgState);
        w = lcgState[31:16];  // Upper bits have the longer period
    endtask

    task automatic driveWord(input logic valid, input logic [dataW-1:0] w);
        @(posedge clk);
        instrValid <= valid;
        instr      <= w;
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = 0;
    endtask

    task automatic finishTest();
        driveWord(1'b0, '0);
        @(posedge clk);  // Last instruction checked by now
        testsRun++;
        if (testErrors != 0) testsFailed++;
        $display("Test %s done, %0d mismatches", testName, testErrors);
    endtask

    task automatic checkEq(input string field, input logic [31:0] expVal,
                           input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("FAIL %s %s: expected %0h, actual %0h", testName, field, expVal, actVal);
            testErrors++;
            totalErrors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare process
    //////////////////////////////////////////////////////////////////////
    always begin
        @(posedge clk);
        if (!rstN) begin
            expValid  = 1'b0;
            expBundle = '0;
        end else if (instrValid) begin
            expValid  = 1'b1;
            expBundle = refDecode(instr);
        end else begin
            expValid           = 1'b0;  // Bubble drops enables, payload holds
            expBundle.regWrite = 1'b0;
            expBundle.memRead  = 1'b0;
            expBundle.memWrite = 1'b0;
            expBundle.jump     = 1'b0;
            expBundle.branch   = 1'b0;
            expBundle.halt     = 1'b0;
            expBundle.err      = 1'b0;
        end
        @(negedge clk);  // Outputs settled mid cycle
        if (expValid && ctrlValid !== 1'b1) begin
            $display("%s: no ctrlValid one cycle after an accepted instruction", testName);
            testErrors++;
            totalErrors++;
        end else if (!expValid && ctrlValid !== 1'b0) begin
            $display("%s: ctrlValid high without an accepted instruction", testName);
            testErrors++;
            totalErrors++;
        end
        checkEq("regWrite", expBundle.regWrite, regWrite);
        checkEq("memRead",  expBundle.memRead,  memRead);
        checkEq("memWrite", expBundle.memWrite, memWrite);
        checkEq("memToReg", expBundle.memToReg, memToReg);
        checkEq("aluSrc",   expBundle.aluSrc,   aluSrc);
        checkEq("jump",     expBundle.jump,     jump);
        checkEq("branch",   expBundle.branch,   branch);
        checkEq("regToPc",  expBundle.regToPc,  regToPc);
        checkEq("pcToReg",  expBundle.pcToReg,  pcToReg);
        checkEq("halt",     expBundle.halt,     halt);
        checkEq("err",      expBundle.err,      err);
        checkEq("writeReg", expBundle.writeReg, writeReg);
        checkEq("aluOp",    expBundle.aluOp,    aluOp);
        checkEq("aluInvA",  expBundle.aluInvA,  aluInvA);
        checkEq("aluInvB",  expBundle.aluInvB,  aluInvB);
        checkEq("aluCin",   expBundle.aluCin,   aluCin);
        checkEq("immValue", expBundle.immValue, immValue);
    end

    // Watchdog
    initial begin
        #(timeoutNs);
        $display("Watchdog: run still going after %0d ns, stopping", timeoutNs);
        $display("Errors found");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [dataW-1:0] r;
        logic [dataW-1:0] v;
        int               i;
        instrValid = 1'b0;
        instr      = '0;

        startTest("reset");  // Valid words during reset must not leak out
        for (i = 0; i < resetCycles - 2; i++) begin
            randWord(r);
            driveWord(1'b1, r);
        end
        driveWord(1'b0, '0);
        wait (rstN);
        repeat (3) @(posedge clk);
        finishTest();

        startTest("opcodeSweep");
        for (i = 0; i < 32; i++) begin
            randWord(r);
            driveWord(1'b1, {i[4:0], r[10:0]});
        end
        finishTest();

        startTest("rFormatFunc");
        for (i = 0; i < 8; i++) begin
            randWord(r);
            driveWord(1'b1, {(i < 4) ? opShiftR : opArithR, r[10:2], i[1:0]});
        end
        finishTest();

        startTest("immAndDest");
        for (i = 0; i < 200; i++) begin
            randWord(r);
            driveWord(1'b1, r);
        end
        finishTest();

        startTest("streamBubbles");
        for (i = 0; i < 300; i++) begin
            randWord(r);
            randWord(v);
            driveWord(v[15], r);
        end
        finishTest();

        $display("Tests run %0d, failed %0d, mismatches %0d", testsRun, testsFailed,
                 totalErrors);
        if (totalErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end
endmodule

`default_nettype wire

//--- mainDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module mainDecoder (
    input  logic [decodePkg::opcodeW-1:0] opcode,
    ctrlIf.decoder                        ctrl
);
    import decodePkg::*;

    always_comb begin
        ctrl.regDst   = dstRs;     // Defaults give a quiet no-op
        ctrl.extSel   = extSign5;
        ctrl.regWrite = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.jump     = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.regToPc  = 1'b0;
        ctrl.pcToReg  = 1'b0;
        ctrl.halt     = 1'b0;
        ctrl.err      = 1'b0;

        case (opcode)
            opHalt: ctrl.halt = 1'b1;
            opNop, opSiic, opRti: begin
                // No exception support so these retire as no-ops
            end

            //////////////////////////////////////////////////////////////////////
            // I format 1
            //////////////////////////////////////////////////////////////////////
            opAddi, opSubi: begin
                ctrl.regDst   = dstRt;     // Rd lives in bits 7..5 here
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.extSel   = extSign5;
            end
            opXori, opAndni, opRoli, opSlli, opRori, opSrli: begin
                ctrl.regDst   = dstRt;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.extSel   = extZero5;  // Logic ops and shift amounts are unsigned
            end
            opSt: begin
                ctrl.aluSrc   = 1'b1;      // Address is Rs + imm
                ctrl.memWrite = 1'b1;
                ctrl.extSel   = extSign5;
            end
            opLd: begin
                ctrl.regDst   = dstRt;
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.extSel   = extSign5;
            end
            opStu: begin
                ctrl.regDst   = dstRs;     // Updated address back into Rs
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.extSel   = extSign5;
            end

            // R format always writes Rd
            opBtr, opShiftR, opArithR, opSeq, opSlt, opSle, opSco: begin
                ctrl.regDst   = dstRd;
                ctrl.regWrite = 1'b1;
            end

            //////////////////////////////////////////////////////////////////////
            // I format 2 and J format
            //////////////////////////////////////////////////////////////////////
            opBeqz, opBnez, opBltz, opBgez: begin
                ctrl.branch = 1'b1;
                ctrl.extSel = extSign8;    // Branch offset
            end
            opLbi: begin
                ctrl.regDst   = dstRs;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.extSel   = extSign8;
            end
            opSlbi: begin
                ctrl.regDst   = dstRs;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.extSel   = extZero8;  // Low byte shifted in as is
            end
            opJ: begin
                ctrl.jump   = 1'b1;
                ctrl.extSel = extSign11;
            end
            opJr: begin
                ctrl.jump    = 1'b1;
                ctrl.aluSrc  = 1'b1;
                ctrl.regToPc = 1'b1;       // Target is Rs + imm
                ctrl.extSel  = extSign8;
            end
            opJal: begin
                ctrl.jump     = 1'b1;
                ctrl.regDst   = dstLink;
                ctrl.regWrite = 1'b1;
                ctrl.pcToReg  = 1'b1;
                ctrl.extSel   = extSign11;
            end
            opJalr: begin
                ctrl.jump     = 1'b1;
                ctrl.regDst   = dstLink;
                ctrl.regWrite = 1'b1;
                ctrl.pcToReg  = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.regToPc  = 1'b1;
                ctrl.extSel   = extSign8;
            end
            default: ctrl.err = 1'b1;      // Unreachable with all 32 opcodes listed
        endcase
    end
endmodule

`default_nettype wire

//--- operandFields.sv
`timescale 1ns/1ns
`default_nettype none

module operandFields (
    input  decodePkg::instrWord_u              instr,
    ctrlIf.fields                              ctrl,
    output logic [decodePkg::dataW-1:0]        immValue,
    output logic [decodePkg::regIdxW-1:0]      writeReg
);
    import decodePkg::*;

    // Immediate extension
    always_comb begin
        case (ctrl.extSel)
            extSign5:  immValue = {{(dataW-5){instr.i1Fmt.imm5[4]}}, instr.i1Fmt.imm5};
            extSign8:  immValue = {{(dataW-8){instr.i2Fmt.imm8[7]}}, instr.i2Fmt.imm8};
            extSign11: immValue = {{(dataW-11){instr.jFmt.disp11[10]}}, instr.jFmt.disp11};
            extZero5:  immValue = {{(dataW-5){1'b0}}, instr.i1Fmt.imm5};
            extZero8:  immValue = {{(dataW-8){1'b0}}, instr.i2Fmt.imm8};
            default:   immValue = '0;  // Codes 5..7 unused
        endcase
    end

    // Destination register
    always_comb begin
        case (ctrl.regDst)
            dstRs:   writeReg = instr.rFmt.rs;
            dstRt:   writeReg = instr.rFmt.rt;  // Same bits as the I format 1 Rd
            dstRd:   writeReg = instr.rFmt.rd;
            default: writeReg = linkReg;        // JAL and JALR
        endcase
    end
endmodule

`default_nettype wire
